/* verilog/credit_cfg.svh */
/*
 * Credit link configuration
 * Sizes of the data word, receiver buffer, item weight and item queue
 */

`ifndef CREDIT_CFG_SVH
`define CREDIT_CFG_SVH

// Width of the item data word
`define CREDIT_DATA_WIDTH 16

// Receiver buffer slots, also the largest credit count
`define CREDIT_MAX_VALUE 24

// Largest weight of one item
`define CREDIT_MAX_CHANGE 4

// Item entries in the receiver queue
// One entry per slot covers every weight
`define CREDIT_ITEM_DEPTH 24

`endif

/* verilog/credit_pkg.sv */
/*
 * Credit link types
 * Credit count, credit change and data word types shared across the link
 */

`include "credit_cfg.svh"

package credit_pkg;

  // Holds 0 to CREDIT_MAX_VALUE
  typedef logic [$clog2(`CREDIT_MAX_VALUE + 1)-1:0] value_t;

  // Holds 0 to CREDIT_MAX_CHANGE
  typedef logic [$clog2(`CREDIT_MAX_CHANGE + 1)-1:0] change_t;

  // Item payload
  typedef logic [`CREDIT_DATA_WIDTH-1:0] data_t;

endpackage

/* verilog/credit_counter.sv */
/*
 * Credit counter
 * Tracks credits with same-cycle increment bypass, a withheld reserve
 * and a decrement grant that only fires when the change fits
 */

`timescale 1ns/1ps

module credit_counter (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                incr_valid,
  input  credit_pkg::change_t incr,
  input  logic                decr_valid,
  input  credit_pkg::change_t decr,
  input  credit_pkg::value_t  initial_value,
  input  credit_pkg::value_t  withhold,
  output logic                decr_ready,
  output credit_pkg::value_t  value,
  output credit_pkg::value_t  available
);

  localparam int VW = $bits(credit_pkg::value_t);

  // One spare bit so value plus increment cannot wrap
  logic [VW:0] incr_amt;
  logic [VW:0] decr_amt;
  logic [VW:0] bypass;
  logic [VW:0] withhold_ext;
  logic [VW:0] next_value;

  assign incr_amt = incr_valid ? (VW + 1)'(incr) : '0;

  // Returned credits count toward this cycle's spend
  assign bypass = (VW + 1)'(value) + incr_amt;
  assign withhold_ext = (VW + 1)'(withhold);

  // Reserve is subtracted with a floor at zero
  always_comb begin
    if (bypass > withhold_ext) begin
      available = credit_pkg::value_t'(bypass - withhold_ext);
    end else begin
      available = '0;
    end
  end

  // Grant only when the whole change fits in what is spendable
  assign decr_ready = ((VW + 1)'(decr) <= (VW + 1)'(available)) && (available != '0);

  assign decr_amt = (decr_valid && decr_ready) ? (VW + 1)'(decr) : '0;
  assign next_value = bypass - decr_amt;

  // Initial value is reloaded on every reset cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      value <= initial_value;
    end else begin
      value <= credit_pkg::value_t'(next_value);
    end
  end

endmodule

/* verilog/credit_sender.sv */
/*
 * Credit sender
 * Accepts weighted requests against the credit counter and puts each
 * accepted item on the link as a one-cycle pulse
 */

`timescale 1ns/1ps

module credit_sender (
  input  logic                clk,
  input  logic                rst_n,

  // Request side
  input  logic                req_valid,
  input  credit_pkg::data_t   req_data,
  input  credit_pkg::change_t req_weight,
  output logic                req_ready,

  // Counter configuration
  input  credit_pkg::value_t  initial_credit,
  input  credit_pkg::value_t  withhold,

  // Credits coming back from the receiver
  input  logic                ret_valid,
  input  credit_pkg::change_t ret_weight,

  // Link towards the receiver
  output logic                link_valid,
  output credit_pkg::data_t   link_data,
  output credit_pkg::change_t link_weight,

  // Observation
  output credit_pkg::value_t  value,
  output credit_pkg::value_t  available
);

  logic decr_ready;
  logic accept;

  // A request is a decrement of its weight
  credit_counter u_counter (
    .clk           (clk),
    .rst_n         (rst_n),
    .incr_valid    (ret_valid),
    .incr          (ret_weight),
    .decr_valid    (req_valid),
    .decr          (req_weight),
    .initial_value (initial_credit),
    .withhold      (withhold),
    .decr_ready    (decr_ready),
    .value         (value),
    .available     (available)
  );

  assign req_ready = decr_ready;
  assign accept = req_valid && decr_ready;

  // Link strobe rises one cycle after acceptance
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      link_valid <= 1'b0;
    end else begin
      link_valid <= accept;
    end
  end

  // Payload only moves on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      link_data <= req_data;
      link_weight <= req_weight;
    end
  end

endmodule

/* verilog/credit_receiver.sv */
/*
 * Credit receiver
 * In-order item queue fed by the link and drained by the sink;
 * each popped item returns its weight as credits one cycle later
 */

`timescale 1ns/1ps

`include "credit_cfg.svh"

module credit_receiver (
  input  logic                clk,
  input  logic                rst_n,

  // Link from the sender
  input  logic                link_valid,
  input  credit_pkg::data_t   link_data,
  input  credit_pkg::change_t link_weight,

  // Sink
  output logic                sink_valid,
  output credit_pkg::data_t   sink_data,
  output credit_pkg::change_t sink_weight,
  input  logic                sink_ready,

  // Credit return
  output logic                ret_valid,
  output credit_pkg::change_t ret_weight
);

  localparam int DEPTH = `CREDIT_ITEM_DEPTH;
  localparam int PW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  credit_pkg::data_t   data_mem   [DEPTH];
  credit_pkg::change_t weight_mem [DEPTH];

  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          push;
  logic          pop;

  // The link has no back-pressure since credits guarantee the space
  assign push = link_valid;
  assign pop = sink_valid && sink_ready;

  // Oldest entry is always on the sink
  assign sink_valid = (count != '0);
  assign sink_data = data_mem[rd_ptr];
  assign sink_weight = weight_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      data_mem[wr_ptr] <= link_data;
      weight_mem[wr_ptr] <= link_weight;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Return strobe trails the pop by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ret_valid <= 1'b0;
    end else begin
      ret_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      ret_weight <= weight_mem[rd_ptr];
    end
  end

endmodule

/* verilog/credit_link_top.sv */
/*
 * Credit link top
 * Sender with its credit counter, joined to the receiver by the item
 * link and the credit return path
 */

`timescale 1ns/1ps

module credit_link_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid,
  input  credit_pkg::data_t   req_data,
  input  credit_pkg::change_t req_weight,
  output logic                req_ready,
  input  credit_pkg::value_t  initial_credit,
  input  credit_pkg::value_t  withhold,
  output logic                sink_valid,
  output credit_pkg::data_t   sink_data,
  output credit_pkg::change_t sink_weight,
  input  logic                sink_ready,
  output credit_pkg::value_t  value,
  output credit_pkg::value_t  available
);

  // Link
  logic                link_valid;
  credit_pkg::data_t   link_data;
  credit_pkg::change_t link_weight;

  // Credit return
  logic                ret_valid;
  credit_pkg::change_t ret_weight;

  credit_sender u_sender (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid      (req_valid),
    .req_data       (req_data),
    .req_weight     (req_weight),
    .req_ready      (req_ready),
    .initial_credit (initial_credit),
    .withhold       (withhold),
    .ret_valid      (ret_valid),
    .ret_weight     (ret_weight),
    .link_valid     (link_valid),
    .link_data      (link_data),
    .link_weight    (link_weight),
    .value          (value),
    .available      (available)
  );

  credit_receiver u_receiver (
    .clk         (clk),
    .rst_n       (rst_n),
    .link_valid  (link_valid),
    .link_data   (link_data),
    .link_weight (link_weight),
    .sink_valid  (sink_valid),
    .sink_data   (sink_data),
    .sink_weight (sink_weight),
    .sink_ready  (sink_ready),
    .ret_valid   (ret_valid),
    .ret_weight  (ret_weight)
  );

endmodule

/* testbench/credit_checker.sv */
/*
 * Credit link checker
 * Mirrors the credit count and the item order from the DUT ports
 * and reports every mismatch as it is seen
 */

`timescale 1ns/1ps

`include "credit_cfg.svh"

module credit_checker (
  input  logic                clk,
  input  logic                rst_n,
  input  int                  test_id,
  input  logic                idle_check,
  input  logic                req_valid,
  input  credit_pkg::data_t   req_data,
  input  credit_pkg::change_t req_weight,
  input  logic                req_ready,
  input  credit_pkg::value_t  initial_credit,
  input  credit_pkg::value_t  withhold,
  input  logic                sink_valid,
  input  credit_pkg::data_t   sink_data,
  input  credit_pkg::change_t sink_weight,
  input  logic                sink_ready,
  input  credit_pkg::value_t  value,
  input  credit_pkg::value_t  available,
  output int                  errors
);

  credit_pkg::data_t exp_data [$];
  int                exp_weight [$];
  int                model_value;
  int                outstanding;
  int                prev_ret;
  bit                was_reset;
  int                err_count = 0;

  assign errors = err_count;

  // Spendable credit is the count plus the same-cycle return less the reserve
  function automatic int expected_available(input int val, input int incr, input int hold);
    int spendable;
    spendable = val + incr - hold;
    if (spendable > 0) return spendable;
    return 0;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1: return "reset_load";
      2: return "random_traffic";
      3: return "withhold_traffic";
      4: return "drain";
      5: return "backpressure_withhold";
      default: return "idle";
    endcase
  endfunction

  task automatic report_value(input string what, input int exp, input int act);
    err_count++;
    $display("error %s: %s expected %0d actual %0d", test_name(test_id), what, exp, act);
  endtask

  task automatic report_fault(input string msg);
    err_count++;
    $display("error %s: %s", test_name(test_id), msg);
  endtask

  // Sampled mid-cycle, where inputs and outputs are both settled
  always @(negedge clk) begin : sample
    int  incr;
    int  exp_av;
    int  take;
    bit  rule_ready;
    if (!rst_n) begin
      model_value = int'(initial_credit);
      prev_ret = 0;
      outstanding = 0;
      exp_data.delete();
      exp_weight.delete();
      was_reset = 1'b1;
    end else begin
      incr = prev_ret;
      exp_av = expected_available(model_value, incr, int'(withhold));
      if (was_reset && sink_valid) report_fault("sink_valid is high right after reset");
      was_reset = 1'b0;
      if (int'(value) != model_value) report_value("value", model_value, int'(value));
      if (int'(available) != exp_av) report_value("available", exp_av, int'(available));
      rule_ready = (int'(req_weight) <= exp_av) && (exp_av != 0);
      if (req_ready != rule_ready) report_value("req_ready", int'(rule_ready), int'(req_ready));

      take = 0;
      if (req_valid && req_ready) begin
        exp_data.push_back(req_data);
        exp_weight.push_back(int'(req_weight));
        take = int'(req_weight);
        outstanding += take;
        if (outstanding > `CREDIT_MAX_VALUE) begin
          report_value("outstanding weight", `CREDIT_MAX_VALUE, outstanding);
        end
      end

      // A pop returns its weight on the next cycle
      prev_ret = 0;
      if (sink_valid && sink_ready) begin
        if (exp_data.size() == 0) begin
          report_fault("sink popped an item that was never accepted");
        end else begin
          if (sink_data != exp_data[0]) begin
            report_value("sink_data", int'(exp_data[0]), int'(sink_data));
          end
          if (int'(sink_weight) != exp_weight[0]) begin
            report_value("sink_weight", exp_weight[0], int'(sink_weight));
          end
          prev_ret = exp_weight[0];
          outstanding -= prev_ret;
          void'(exp_data.pop_front());
          void'(exp_weight.pop_front());
        end
      end

      if (idle_check) begin
        if (value != initial_credit) begin
          report_value("drained value", int'(initial_credit), int'(value));
        end
        if (exp_data.size() != 0) report_value("items left", 0, exp_data.size());
      end

      model_value = model_value + incr - take;
    end
  end

endmodule

/* testbench/tb_credit_link.sv */
/*
 * Credit link testbench
 * Drives random weighted traffic, sink stalls and withhold changes
 * through the link and reports each test
 */

`timescale 1ns/1ps

`include "credit_cfg.svh"

module tb_credit_link;

  logic                clk;
  logic                rst_n;
  logic                req_valid;
  credit_pkg::data_t   req_data;
  credit_pkg::change_t req_weight;
  logic                req_ready;
  credit_pkg::value_t  initial_credit;
  credit_pkg::value_t  withhold;
  logic                sink_valid;
  credit_pkg::data_t   sink_data;
  credit_pkg::change_t sink_weight;
  logic                sink_ready;
  credit_pkg::value_t  value;
  credit_pkg::value_t  available;
  int                  test_id;
  logic                idle_check;
  int                  errors;

  // Sink mode 0 gives random stalls, 1 holds ready low, 2 keeps it high
  int          sink_mode;
  logic [31:0] req_seed;
  logic [31:0] sink_seed;
  bit          hung;
  int          tests_run;
  int          start_errors;

  credit_link_top dut (.*);

  credit_checker chk (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Mode is taken at the edge, before the main sequence can change it
  initial begin : sink_drive
    int mode;
    sink_seed = lcg_next(32'd73);
    forever begin
      @(posedge clk);
      mode = sink_mode;
      #1;
      sink_seed = lcg_next(sink_seed);
      case (mode)
        1: sink_ready = 1'b0;
        2: sink_ready = 1'b1;
        default: sink_ready = (sink_seed[31:30] != 2'b00);
      endcase
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic draw(input int range, output int result);
    req_seed = lcg_next(req_seed);
    result = int'(req_seed[31:16]) % range;
  endtask

  task automatic begin_test(input int id);
    test_id = id;
    start_errors = errors;
  endtask

  task automatic end_test(input string name);
    next_cycle();
    tests_run++;
    $display("test %s: %0d errors", name, errors - start_errors);
  endtask

  // Holds the request until it is granted or the limit runs out
  task automatic send_item(input credit_pkg::data_t word, input int weight, input int limit,
                           output bit accepted);
    int waited;
    accepted = 1'b0;
    waited = 0;
    req_valid = 1'b1;
    req_data = word;
    req_weight = credit_pkg::change_t'(weight);
    while (!accepted && waited < limit) begin
      @(negedge clk);
      if (req_ready) accepted = 1'b1;
      next_cycle();
      waited++;
    end
    req_valid = 1'b0;
  endtask

  task automatic send_random(input int count, input int hold_max);
    int i;
    int word;
    int weight;
    int gap;
    int hold;
    bit accepted;
    for (i = 0; i < count && !hung; i++) begin
      draw(65536, word);
      draw(`CREDIT_MAX_CHANGE, weight);
      draw(4, gap);
      if (hold_max > 0) begin
        draw(hold_max + 1, hold);
        withhold = credit_pkg::value_t'(hold);
      end
      send_item(credit_pkg::data_t'(word), weight + 1, 100, accepted);
      if (!accepted) begin
        $display("timeout: request %0d was not accepted within 100 cycles", i);
        hung = 1'b1;
      end
      repeat (gap) next_cycle();
    end
  endtask

  // Empty the receiver, then let the last return reach the count
  task automatic drain_sink();
    int waited;
    sink_mode = 2;
    waited = 0;
    // An item accepted on the last edge reaches the receiver one cycle later
    next_cycle();
    @(negedge clk);
    while (sink_valid && waited < 200) begin
      @(negedge clk);
      waited++;
    end
    if (sink_valid) begin
      $display("timeout: sink did not drain within 200 cycles");
      hung = 1'b1;
    end else begin
      @(posedge clk);
      #1;
      idle_check = 1'b1;
      next_cycle();
      idle_check = 1'b0;
    end
  endtask

  task automatic run_backpressure();
    int i;
    bit accepted;
    sink_mode = 1;
    withhold = '0;
    accepted = 1'b1;
    // Weight 4 items until the credit runs out
    for (i = 0; i < 10 && accepted; i++) begin
      send_item(credit_pkg::data_t'(16'h4000 + i), `CREDIT_MAX_CHANGE, 6, accepted);
    end
    drain_sink();
    if (!hung) begin
      sink_mode = 1;
      withhold = initial_credit;
      send_item(16'h5a5a, 1, 16, accepted);
      withhold = '0;
      sink_mode = 0;
      send_random(8, 0);
      drain_sink();
    end
  endtask

  initial begin
    rst_n = 1'b0;
    req_valid = 1'b0;
    req_data = '0;
    req_weight = credit_pkg::change_t'(1);
    initial_credit = credit_pkg::value_t'(`CREDIT_MAX_VALUE);
    withhold = '0;
    sink_ready = 1'b0;
    sink_mode = 1;
    idle_check = 1'b0;
    req_seed = 32'd73;
    hung = 1'b0;
    tests_run = 0;
    begin_test(1);
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();
    end_test("reset_load");

    begin_test(2);
    sink_mode = 0;
    send_random(200, 0);
    end_test("random_traffic");

    if (!hung) begin
      begin_test(3);
      send_random(100, 6);
      withhold = '0;
      end_test("withhold_traffic");
    end

    if (!hung) begin
      begin_test(4);
      drain_sink();
      end_test("drain");
    end

    if (!hung) begin
      begin_test(5);
      run_backpressure();
      end_test("backpressure_withhold");
    end

    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0 && !hung) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+verilog
verilog/credit_pkg.sv
verilog/credit_counter.sv
verilog/credit_sender.sv
verilog/credit_receiver.sv
verilog/credit_link_top.sv
testbench/credit_checker.sv
testbench/tb_credit_link.sv

/* run.sh */
#!/bin/sh
# Build and run the credit link testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f list.f \
  --top-module tb_credit_link \
  -Mdir obj_dir \
  -o sim_credit_link

./obj_dir/sim_credit_link > sim.log 2>&1
cat sim.log

# The run passes only if the testbench printed its pass line
grep -q "^Done: no errors$" sim.log
echo "simulation passed"
